// ==== Bender.yml ====
package:
  name: alu_core

sources:
  - rtl/core_pkg.sv
  - rtl/instr_queue.sv
  - rtl/reg_file.sv
  - rtl/decode_stage.sv
  - rtl/execute_stage.sv
  - rtl/alu_core.sv
  - target: simulation
    files:
      - dv/alu_core_assert.sv
      - dv/tb_alu_core.sv

// ==== dv/alu_core_assert.sv ====
//--------------------------------------------------------------------------
// Integer core assertions
// Queue protocol and writeback invariants, bound into the core top
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module alu_core_assert import core_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input logic      instr_valid,
	input logic      q_full,
	input logic      credit_return,
	input logic      wb_valid,
	input reg_addr_t wb_reg
);

	int fail_count = 0;  // Failed assertions so far
	int occupancy;       // Sent entries whose credit is still out

	// Occupancy seen from the channel side
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			occupancy <= 0;
		else
			occupancy <= occupancy + int'(instr_valid) - int'(credit_return);
	end

	// Sender spent a credit it did not have
	no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		!(instr_valid && q_full))
		else
		begin
			fail_count++;
			$error("instruction offered while the queue is full");
		end

	no_credit_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!(credit_return && occupancy == 0))
		else
		begin
			fail_count++;
			$error("credit returned from an empty queue");
		end

	no_write_to_r0: assert property (@(posedge clk) disable iff (!rst_n)
		!(wb_valid && wb_reg == '0))
		else
		begin
			fail_count++;
			$error("writeback targets r0");
		end

endmodule

bind alu_core alu_core_assert u_assert
(
	.clk           (clk),
	.rst_n         (rst_n),
	.instr_valid   (instr_valid),
	.q_full        (u_queue.full),   // Queue internals
	.credit_return (credit_return),
	.wb_valid      (wb_valid),
	.wb_reg        (wb_reg)
);

// ==== dv/tb_alu_core.sv ====
//--------------------------------------------------------------------------
// Integer core testbench
// Credit-limited random MIPS ALU stream, in-order reference model with a
// shadow register file, per-cycle checks of credits and writebacks
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module tb_alu_core import core_pkg::*; ();

	localparam int          N_INSTR    = 2000;         // Instructions to send
	localparam int          MAX_CYCLES = 20000;        // Drain watchdog
	localparam logic [31:0] SEED       = 32'h51fa_a0ae;

	// DUT ports
	logic      clk;
	logic      rst_n;
	logic      instr_valid;
	instr_t    instr;
	logic      credit_return;
	logic      wb_valid;
	reg_addr_t wb_reg;
	word_t     wb_data;

	// Sender and model state
	logic [31:0] rng;
	int          cycle;           // Edges since reset release
	int          credits;         // Sender's credit count
	int          n_sent;
	logic        prev_accept;     // Accepted at the previous edge
	word_t       shadow [32];     // Reference register file
	int          exp_cycle [$];   // Edge at which each writeback is due
	reg_addr_t   exp_reg [$];
	word_t       exp_data [$];

	alu_core u_alu_core
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_valid   (instr_valid),
		.instr         (instr),
		.credit_return (credit_return),
		.wb_valid      (wb_valid),
		.wb_reg        (wb_reg),
		.wb_data       (wb_data)
	);

	//----------------------------------------------------------------------
	// Random stimulus
	//----------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// Mostly r0..r3 so results feed the next instructions
	function automatic reg_addr_t pick_reg();
		logic [31:0] r;
		r = next_rand();
		if (r[3:0] < 4'd13)
			return {3'b000, r[5:4]};
		return r[10:6];
	endfunction

	function automatic instr_t gen_instr();
		logic [31:0] r;
		logic [5:0]  op;
		logic [5:0]  fn;
		reg_addr_t   rs;
		reg_addr_t   rt;
		reg_addr_t   rd;
		r  = next_rand();
		rs = pick_reg();
		rt = pick_reg();
		rd = pick_reg();
		op = OP_RTYPE;
		fn = FN_ADD;
		case (r[31:24] % 18)
			0:       fn = FN_SLL;
			1:       fn = FN_SRL;
			2:       fn = FN_SRA;
			3:       fn = FN_ADD;
			4:       fn = FN_SUB;
			5:       fn = FN_AND;
			6:       fn = FN_OR;
			7:       fn = FN_XOR;
			8:       fn = FN_NOR;
			9:       fn = FN_SLT;
			10:      op = OP_ADDI;
			11:      op = OP_SLTI;
			12:      op = OP_ANDI;
			13:      op = OP_ORI;
			14:      op = OP_XORI;
			15:      op = OP_LUI;
			16:      fn = 6'd33;   // ADDU, unsupported funct
			default: op = 6'd35;   // LW, unsupported opcode
		endcase
		if (op == OP_RTYPE)
			return {op, rs, rt, rd, r[10:6], fn};
		return {op, rs, rt, r[15:0]};
	endfunction

	//----------------------------------------------------------------------
	// Reference model, applied strictly in acceptance order
	//----------------------------------------------------------------------
	task automatic apply_model(input instr_t in);
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] sh;
		word_t      a;
		word_t      b;
		word_t      sext;
		word_t      zext;
		word_t      res;
		reg_addr_t  dest;
		logic       known;
		op    = in[31:26];
		fn    = in[5:0];
		sh    = in[10:6];
		a     = shadow[in[25:21]];
		b     = shadow[in[20:16]];
		sext  = {{16{in[15]}}, in[15:0]};
		zext  = {16'h0000, in[15:0]};
		dest  = (op == OP_RTYPE) ? in[15:11] : in[20:16];  // rd or rt
		known = 1'b1;
		res   = '0;
		case (op)
			OP_RTYPE:
			begin
				case (fn)
					FN_SLL:  res = b << sh;
					FN_SRL:  res = b >> sh;
					FN_SRA:  res = $signed(b) >>> sh;
					FN_ADD:  res = a + b;
					FN_SUB:  res = a - b;
					FN_AND:  res = a & b;
					FN_OR:   res = a | b;
					FN_XOR:  res = a ^ b;
					FN_NOR:  res = ~(a | b);
					FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
					default: known = 1'b0;
				endcase
			end
			OP_ADDI: res = a + sext;
			OP_SLTI: res = {31'd0, $signed(a) < $signed(sext)};
			OP_ANDI: res = a & zext;
			OP_ORI:  res = a | zext;
			OP_XORI: res = a ^ zext;
			OP_LUI:  res = {in[15:0], 16'h0000};
			default: known = 1'b0;                     // No-op
		endcase
		if (known && dest != 5'd0)
		begin
			shadow[dest] = res;
			exp_cycle.push_back(cycle + 3);            // Fixed 3-cycle latency
			exp_reg.push_back(dest);
			exp_data.push_back(res);
		end
	endtask

	//----------------------------------------------------------------------
	// Error reporting and checks
	//----------------------------------------------------------------------
	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("FAIL t=%0t %s expected 0x%h got 0x%h", $time, name, expected, actual);
		$display("sim failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic report_error(input string msg);
		$display("ERROR t=%0t %s", $time, msg);
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_writeback();
		if (wb_valid === 1'b1)
		begin
			assert (exp_cycle.size() > 0)
				else report_error("writeback seen with no instruction expecting one");
			assert (exp_cycle[0] == cycle)
				else report_mismatch("wb_valid cycle", exp_cycle[0], cycle);
			assert (wb_reg === exp_reg[0])
				else report_mismatch("wb_reg", exp_reg[0], wb_reg);
			assert (wb_data === exp_data[0])
				else report_mismatch("wb_data", exp_data[0], wb_data);
			void'(exp_cycle.pop_front());
			void'(exp_reg.pop_front());
			void'(exp_data.pop_front());
		end
		else
		begin
			assert (wb_valid === 1'b0)
				else report_error("wb_valid is unknown");
		end
		if (exp_cycle.size() > 0)                     // Oldest one overdue?
			assert (exp_cycle[0] > cycle)
				else report_error("expected writeback did not appear");
	endtask

	// One clock edge: sample, check, model, then drive the sender
	task automatic step_cycle();
		logic        accepted;
		instr_t      taken;
		instr_t      next_instr;
		logic [31:0] r;
		@(posedge clk);
		cycle++;
		assert (u_alu_core.u_assert.fail_count == 0)
			else report_error("a bound queue or writeback assertion failed");
		accepted = instr_valid;                       // Pre-edge values
		taken    = instr;
		assert (credit_return === prev_accept)
			else report_mismatch("credit_return", prev_accept, credit_return);
		if (accepted)
			credits--;
		if (credit_return)
			credits++;
		assert (credits >= 0 && credits <= QUEUE_DEPTH)
			else report_error("sender credit count left its legal range");
		prev_accept = accepted;
		check_writeback();
		if (accepted)
			apply_model(taken);
		r = next_rand();
		if (n_sent < N_INSTR && credits > 0 && r[2:0] != 3'd0)
		begin
			next_instr = gen_instr();
			instr_valid <= 1'b1;
			instr       <= next_instr;
			n_sent++;
		end
		else
		begin
			instr_valid <= 1'b0;
			instr       <= r;                         // Junk while idle
		end
	endtask

	//----------------------------------------------------------------------
	// Clock, reset and main sequence
	//----------------------------------------------------------------------
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		int guard;
		rng         = SEED;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		cycle       = 0;
		credits     = QUEUE_DEPTH;
		n_sent      = 0;
		prev_accept = 1'b0;
		for (int i = 0; i < 32; i++)
			shadow[i] = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		guard = 0;
		while (n_sent < N_INSTR || exp_cycle.size() > 0)
		begin
			step_cycle();
			guard++;
			if (guard > MAX_CYCLES)
				report_error("timeout while waiting for the stream to drain");
		end
		repeat (4) step_cycle();                      // Quiet tail
		@(negedge clk);                               // Last edge's assertions settle
		if (exp_cycle.size() == 0 && credits == QUEUE_DEPTH &&
			u_alu_core.u_assert.fail_count == 0)
		begin
			$display("sim passed");
			$finish;
		end
		else
			report_error("run ended with missing writebacks, lost credits or assertion failures");
	end

endmodule

// ==== rtl/alu_core.sv ====
//--------------------------------------------------------------------------
// Integer core top
// Credit-fed instruction queue, decode with register read, execute with
// forwarding and writeback to the register file and output ports
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module alu_core import core_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      instr_valid,
	input  instr_t    instr,
	output logic      credit_return,
	output logic      wb_valid,
	output reg_addr_t wb_reg,
	output word_t     wb_data
);

	// Queue to decode
	logic       q_valid;
	instr_t     q_instr;

	// Register file read
	reg_addr_t  rs_addr;
	reg_addr_t  rt_addr;
	word_t      rs_data;
	word_t      rt_data;

	// ID/EX
	logic       id_valid;
	reg_addr_t  id_rs;
	reg_addr_t  id_rt;
	word_t      id_op_a;
	word_t      id_op_b;
	word_t      id_imm;
	logic       id_use_imm;
	alu_op_t    id_alu_op;
	logic [4:0] id_shamt;
	logic       id_write;
	reg_addr_t  id_dest;

	// EX/WB
	logic       ex_valid;
	logic       ex_write;
	reg_addr_t  ex_dest;
	word_t      ex_result;

	assign wb_valid = ex_valid && ex_write;  // Also the register write enable
	assign wb_reg   = ex_dest;
	assign wb_data  = ex_result;

	instr_queue u_queue
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_valid   (instr_valid),
		.instr         (instr),
		.q_valid       (q_valid),
		.q_instr       (q_instr),
		.credit_return (credit_return)
	);

	decode_stage u_decode
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.q_valid    (q_valid),
		.q_instr    (q_instr),
		.rs_addr    (rs_addr),
		.rt_addr    (rt_addr),
		.rs_data    (rs_data),
		.rt_data    (rt_data),
		.id_valid   (id_valid),
		.id_rs      (id_rs),
		.id_rt      (id_rt),
		.id_op_a    (id_op_a),
		.id_op_b    (id_op_b),
		.id_imm     (id_imm),
		.id_use_imm (id_use_imm),
		.id_alu_op  (id_alu_op),
		.id_shamt   (id_shamt),
		.id_write   (id_write),
		.id_dest    (id_dest)
	);

	reg_file u_regs
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.we      (wb_valid),
		.wr_addr (ex_dest),
		.wr_data (ex_result)
	);

	execute_stage u_execute
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.id_valid   (id_valid),
		.id_rs      (id_rs),
		.id_rt      (id_rt),
		.id_op_a    (id_op_a),
		.id_op_b    (id_op_b),
		.id_imm     (id_imm),
		.id_use_imm (id_use_imm),
		.id_alu_op  (id_alu_op),
		.id_shamt   (id_shamt),
		.id_write   (id_write),
		.id_dest    (id_dest),
		.ex_valid   (ex_valid),
		.ex_write   (ex_write),
		.ex_dest    (ex_dest),
		.ex_result  (ex_result)
	);

endmodule

// ==== rtl/core_pkg.sv ====
//--------------------------------------------------------------------------
// Core package
// Widths, MIPS opcode and function codes, ALU operation codes and the
// instruction queue depth shared by every stage of the integer core
//--------------------------------------------------------------------------

package core_pkg;

	//----------------------------------------------------------------------
	// Widths and basic types
	//----------------------------------------------------------------------
	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int ALU_OP_W   = 4;

	typedef logic [WORD_W-1:0]     word_t;      // Data word
	typedef logic [WORD_W-1:0]     instr_t;     // Raw instruction
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // Register index
	typedef logic [ALU_OP_W-1:0]   alu_op_t;    // ALU operation

	//----------------------------------------------------------------------
	// Instruction queue
	//----------------------------------------------------------------------
	localparam int QUEUE_DEPTH = 4;                     // Also initial sender credits
	localparam int QPTR_W      = $clog2(QUEUE_DEPTH);   // Pointer width

	//----------------------------------------------------------------------
	// ALU operation codes
	//----------------------------------------------------------------------
	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_AND = 4'd2;
	localparam alu_op_t ALU_OR  = 4'd3;
	localparam alu_op_t ALU_XOR = 4'd4;
	localparam alu_op_t ALU_NOR = 4'd5;
	localparam alu_op_t ALU_SLT = 4'd6;   // Signed compare
	localparam alu_op_t ALU_SLL = 4'd7;
	localparam alu_op_t ALU_SRL = 4'd8;
	localparam alu_op_t ALU_SRA = 4'd9;
	localparam alu_op_t ALU_LUI = 4'd10;  // Immediate into upper half

	// Opcodes, bits 31:26
	localparam logic [5:0] OP_RTYPE = 6'd0;
	localparam logic [5:0] OP_ADDI  = 6'd8;
	localparam logic [5:0] OP_SLTI  = 6'd10;
	localparam logic [5:0] OP_ANDI  = 6'd12;
	localparam logic [5:0] OP_ORI   = 6'd13;
	localparam logic [5:0] OP_XORI  = 6'd14;
	localparam logic [5:0] OP_LUI   = 6'd15;

	// R-type function codes, bits 5:0
	localparam logic [5:0] FN_SLL = 6'd0;
	localparam logic [5:0] FN_SRL = 6'd2;
	localparam logic [5:0] FN_SRA = 6'd3;
	localparam logic [5:0] FN_ADD = 6'd32;
	localparam logic [5:0] FN_SUB = 6'd34;
	localparam logic [5:0] FN_AND = 6'd36;
	localparam logic [5:0] FN_OR  = 6'd37;
	localparam logic [5:0] FN_XOR = 6'd38;
	localparam logic [5:0] FN_NOR = 6'd39;
	localparam logic [5:0] FN_SLT = 6'd42;

endpackage

// ==== rtl/decode_stage.sv ====
//--------------------------------------------------------------------------
// Decode stage
// Splits the instruction, maps opcode and function onto an ALU code,
// extends the immediate, reads the register file and loads ID/EX
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module decode_stage import core_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       q_valid,
	input  instr_t     q_instr,
	output reg_addr_t  rs_addr,
	output reg_addr_t  rt_addr,
	input  word_t      rs_data,
	input  word_t      rt_data,
	output logic       id_valid,
	output reg_addr_t  id_rs,
	output reg_addr_t  id_rt,
	output word_t      id_op_a,
	output word_t      id_op_b,
	output word_t      id_imm,
	output logic       id_use_imm,
	output alu_op_t    id_alu_op,
	output logic [4:0] id_shamt,
	output logic       id_write,
	output reg_addr_t  id_dest
);

	logic [5:0]  opcode;
	logic [5:0]  funct;
	reg_addr_t   f_rs;
	reg_addr_t   f_rt;
	reg_addr_t   f_rd;
	logic [4:0]  f_shamt;
	logic [15:0] imm16;
	alu_op_t     alu_op;
	logic        supported;
	logic        use_imm;
	word_t       imm_ext;
	reg_addr_t   dest;

	// Field split
	assign opcode  = q_instr[31:26];
	assign f_rs    = q_instr[25:21];
	assign f_rt    = q_instr[20:16];
	assign f_rd    = q_instr[15:11];
	assign f_shamt = q_instr[10:6];
	assign funct   = q_instr[5:0];
	assign imm16   = q_instr[15:0];

	assign rs_addr = f_rs;  // Register file read
	assign rt_addr = f_rt;
	assign dest    = (opcode == OP_RTYPE) ? f_rd : f_rt;

	//----------------------------------------------------------------------
	// Opcode and function decode
	//----------------------------------------------------------------------
	always_comb
	begin
		alu_op    = ALU_ADD;
		supported = 1'b1;
		use_imm   = 1'b1;
		imm_ext   = {16'h0000, imm16};      // Zero-extend unless told otherwise
		case (opcode)
			OP_RTYPE:
			begin
				use_imm = 1'b0;
				case (funct)
					FN_SLL:  alu_op = ALU_SLL;
					FN_SRL:  alu_op = ALU_SRL;
					FN_SRA:  alu_op = ALU_SRA;
					FN_ADD:  alu_op = ALU_ADD;
					FN_SUB:  alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_NOR:  alu_op = ALU_NOR;
					FN_SLT:  alu_op = ALU_SLT;
					default: supported = 1'b0;  // Unknown funct is a no-op
				endcase
			end
			OP_ADDI:
			begin
				alu_op  = ALU_ADD;
				imm_ext = {{16{imm16[15]}}, imm16};
			end
			OP_SLTI:
			begin
				alu_op  = ALU_SLT;
				imm_ext = {{16{imm16[15]}}, imm16};
			end
			OP_ANDI: alu_op = ALU_AND;
			OP_ORI:  alu_op = ALU_OR;
			OP_XORI: alu_op = ALU_XOR;
			OP_LUI:  alu_op = ALU_LUI;      // ALU moves it to the upper half
			default: supported = 1'b0;
		endcase
	end

	//----------------------------------------------------------------------
	// ID/EX register
	//----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			id_valid <= 1'b0;
			id_write <= 1'b0;
		end
		else
		begin
			id_valid <= q_valid;
			id_write <= q_valid && supported && (dest != '0);
		end
	end

	// Payload fields
	always_ff @(posedge clk)
	begin
		id_rs      <= f_rs;
		id_rt      <= f_rt;
		id_op_a    <= rs_data;
		id_op_b    <= rt_data;
		id_imm     <= imm_ext;
		id_use_imm <= use_imm;
		id_alu_op  <= alu_op;
		id_shamt   <= f_shamt;
		id_dest    <= dest;
	end

endmodule

// ==== rtl/execute_stage.sv ====
//--------------------------------------------------------------------------
// Execute stage
// Forwards the EX/WB result into the operands, selects register data or
// the immediate, runs the ALU and loads the EX/WB register
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module execute_stage import core_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       id_valid,
	input  reg_addr_t  id_rs,
	input  reg_addr_t  id_rt,
	input  word_t      id_op_a,
	input  word_t      id_op_b,
	input  word_t      id_imm,
	input  logic       id_use_imm,
	input  alu_op_t    id_alu_op,
	input  logic [4:0] id_shamt,
	input  logic       id_write,
	input  reg_addr_t  id_dest,
	output logic       ex_valid,
	output logic       ex_write,
	output reg_addr_t  ex_dest,
	output word_t      ex_result
);

	logic  fwd_a;     // rs takes EX/WB result
	logic  fwd_b;     // rt takes EX/WB result
	logic  ex_live;   // EX/WB entry will write
	word_t op_a;
	word_t op_b_reg;  // rt value after forwarding
	word_t op_b;
	word_t alu_res;

	//----------------------------------------------------------------------
	// Forwarding unit
	//----------------------------------------------------------------------
	// A live EX/WB entry never targets r0
	assign ex_live = ex_valid && ex_write;
	assign fwd_a   = ex_live && (ex_dest == id_rs);
	assign fwd_b   = ex_live && (ex_dest == id_rt);

	// Operand muxes
	assign op_a     = fwd_a ? ex_result : id_op_a;
	assign op_b_reg = fwd_b ? ex_result : id_op_b;
	assign op_b     = id_use_imm ? id_imm : op_b_reg;  // I-type uses imm

	//----------------------------------------------------------------------
	// ALU
	//----------------------------------------------------------------------
	always_comb
	begin
		case (id_alu_op)
			ALU_ADD: alu_res = op_a + op_b;
			ALU_SUB: alu_res = op_a - op_b;
			ALU_AND: alu_res = op_a & op_b;
			ALU_OR:  alu_res = op_a | op_b;
			ALU_XOR: alu_res = op_a ^ op_b;
			ALU_NOR: alu_res = ~(op_a | op_b);
			ALU_SLT:
			begin
				// Signed compare, result is 0 or 1
				alu_res = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
			end
			ALU_SLL: alu_res = op_b << id_shamt;        // rt shifted by shamt
			ALU_SRL: alu_res = op_b >> id_shamt;
			ALU_SRA: alu_res = $signed(op_b) >>> id_shamt;
			ALU_LUI: alu_res = {op_b[15:0], 16'h0000};  // Imm to upper half
			default: alu_res = '0;
		endcase
	end

	//----------------------------------------------------------------------
	// EX/WB register
	//----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ex_valid <= 1'b0;
			ex_write <= 1'b0;
		end
		else
		begin
			ex_valid <= id_valid;
			ex_write <= id_valid && id_write;
		end
	end

	// Destination and result
	always_ff @(posedge clk)
	begin
		ex_dest   <= id_dest;
		ex_result <= alu_res;
	end

endmodule

// ==== rtl/instr_queue.sv ====
//--------------------------------------------------------------------------
// Instruction queue
// Circular buffer between the credit-based sender and decode. The head
// is popped every cycle the queue holds an entry and each pop returns
// one credit to the sender
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module instr_queue import core_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   instr_valid,
	input  instr_t instr,
	output logic   q_valid,
	output instr_t q_instr,
	output logic   credit_return
);

	instr_t            mem [QUEUE_DEPTH];  // Entry storage
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [QPTR_W:0]   count;              // Occupancy 0..QUEUE_DEPTH
	logic              full;
	logic              empty;
	logic              push;
	logic              pop;

	assign full  = (count == QUEUE_DEPTH[QPTR_W:0]);
	assign empty = (count == '0);
	assign push  = instr_valid && !full;  // Sender should never hit full
	assign pop   = !empty;                // Decode never stalls

	// Head presented whenever non-empty
	assign q_valid       = pop;
	assign q_instr       = mem[rd_ptr];
	assign credit_return = pop;           // One credit back per pop

	// Payload storage
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= instr;
	end

	// Pointers and occupancy
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;        // Both or neither
			endcase
		end
	end

endmodule

// ==== rtl/reg_file.sv ====
//--------------------------------------------------------------------------
// Register file
// 32 x 32 registers, two read ports and one write port. r0 reads zero,
// a write to the register being read is bypassed to the read port
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module reg_file import core_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t rs_addr,
	input  reg_addr_t rt_addr,
	output word_t     rs_data,
	output word_t     rt_data,
	input  logic      we,
	input  reg_addr_t wr_addr,
	input  word_t     wr_data
);

	word_t regs [1:31];  // r0 not stored

	// Read with write-through
	assign rs_data = (rs_addr == '0) ? '0 :
		(we && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 :
		(we && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && wr_addr != '0)  // Writes to r0 dropped
			regs[wr_addr] <= wr_data;
	end

endmodule

// ==== sim.f ====
rtl/core_pkg.sv
rtl/instr_queue.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/alu_core.sv
dv/alu_core_assert.sv
dv/tb_alu_core.sv
